// File: rename_pkg.sv
/* register rename shared definitions */

package rename_pkg;

    // architectural register file
    localparam int AREG_COUNT = 32;  // r0..r31, r0 is an ordinary register here
    localparam int AREG_W     = 5;   // index width for AREG_COUNT

    // rob slot lifecycle
    // EMPTY -> BUSY on allocation at rename
    // BUSY  -> DONE on a completion strobe from an execution unit
    // DONE  -> EMPTY when the slot reaches the head and retires
    typedef enum logic [1:0] {
        ENTRY_EMPTY = 2'd0,  // free slot
        ENTRY_BUSY  = 2'd1,  // renamed, waiting on completion
        ENTRY_DONE  = 2'd2   // completed, waiting for in-order retire
    } entry_state_t;

endpackage

// File: free_list.sv
/* physical register free list */

`timescale 1ns/1ps

module free_list #(
    parameter int PREG_COUNT = 48
) (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          pop,        // rename takes free_head
    input  logic                          push,       // retire returns a register
    input  logic [$clog2(PREG_COUNT)-1:0] push_preg,
    output logic [$clog2(PREG_COUNT)-1:0] free_head,
    output logic                          free_empty
);

    localparam int PREG_W     = $clog2(PREG_COUNT);
    localparam int FREE_DEPTH = PREG_COUNT - rename_pkg::AREG_COUNT;  // unmapped regs at reset
    localparam int FREE_W     = (FREE_DEPTH > 1) ? $clog2(FREE_DEPTH) : 1;
    localparam int CNT_W      = $clog2(FREE_DEPTH + 1);

    logic [PREG_W-1:0] mem [FREE_DEPTH];
    logic [FREE_W-1:0] head;   // oldest free register
    logic [FREE_W-1:0] tail;   // next write slot
    logic [CNT_W-1:0]  count;

    // pointers wrap by hand, the depth need not be a power of two
    function automatic logic [FREE_W-1:0] ptr_next(input logic [FREE_W-1:0] ptr);
        logic [FREE_W-1:0] nxt;
        if (ptr == FREE_W'(FREE_DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    assign free_head  = mem[head];
    assign free_empty = (count == '0);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            // upper registers start free, ascending
            for (int i = 0; i < FREE_DEPTH; i++) begin
                mem[i] <= PREG_W'(rename_pkg::AREG_COUNT + i);
            end
            head  <= '0;
            tail  <= '0;        // full buffer, tail wrapped onto head
            count <= CNT_W'(FREE_DEPTH);
        end else begin
            if (push) begin
                mem[tail] <= push_preg;
                tail      <= ptr_next(tail);
            end
            if (pop) begin
                head <= ptr_next(head);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // both or neither
            endcase
        end
    end

endmodule

// File: rename_map.sv
/* rename map and dispatch */

`timescale 1ns/1ps

module rename_map #(
    parameter int PREG_COUNT = 48,
    parameter int ROB_DEPTH  = 16
) (
    input  logic                              clk,
    input  logic                              rstn,
    // dispatch side
    input  logic                              disp_valid,
    input  logic [rename_pkg::AREG_W-1:0]     disp_sr1,
    input  logic [rename_pkg::AREG_W-1:0]     disp_sr2,
    input  logic [rename_pkg::AREG_W-1:0]     disp_dr,
    input  logic                              disp_imm,
    // free list
    input  logic [$clog2(PREG_COUNT)-1:0]     free_head,
    input  logic                              free_empty,
    output logic                              pop,
    // rob
    input  logic                              rob_full,
    output logic                              alloc,
    output logic [$clog2(ROB_DEPTH)-1:0]      alloc_rob,
    output logic [rename_pkg::AREG_W-1:0]     alloc_areg,
    output logic [$clog2(PREG_COUNT)-1:0]     alloc_preg,
    output logic [$clog2(PREG_COUNT)-1:0]     alloc_old,
    // producer feedback and rename result
    output logic                              stall,
    output logic                              ren_valid,
    output logic [$clog2(PREG_COUNT)-1:0]     ren_sr1_p,
    output logic [$clog2(PREG_COUNT)-1:0]     ren_sr2_p,
    output logic [$clog2(PREG_COUNT)-1:0]     ren_dr_p,
    output logic [$clog2(PREG_COUNT)-1:0]     ren_old_p,
    output logic [$clog2(ROB_DEPTH)-1:0]      ren_rob
);

    localparam int PREG_W = $clog2(PREG_COUNT);
    localparam int ROB_W  = $clog2(ROB_DEPTH);

    logic [PREG_W-1:0] alias_tbl [rename_pkg::AREG_COUNT];  // areg -> current preg
    logic [ROB_W-1:0]  tail;                                // next rob slot to hand out
    logic              accept;
    logic [PREG_W-1:0] sr1_p;
    logic [PREG_W-1:0] sr2_p;

    // no free register or no rob slot means the strobe is dropped
    assign stall  = free_empty | rob_full;
    assign accept = disp_valid & ~stall;

    // lookups read the table before this cycle's write,
    // so a source equal to the destination sees the old mapping
    assign sr1_p = alias_tbl[disp_sr1];
    assign sr2_p = disp_imm ? '0 : alias_tbl[disp_sr2];  // immediate has no second source

    // allocation request, same edge as the table write
    assign pop        = accept;
    assign alloc      = accept;
    assign alloc_rob  = tail;
    assign alloc_areg = disp_dr;
    assign alloc_preg = free_head;
    assign alloc_old  = alias_tbl[disp_dr];  // displaced mapping freed at retire

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < rename_pkg::AREG_COUNT; i++) begin
                alias_tbl[i] <= PREG_W'(i);  // identity map
            end
            tail <= '0;
        end else if (accept) begin
            alias_tbl[disp_dr] <= free_head;
            tail               <= tail + 1'b1;  // power-of-two depth wraps on its own
        end
    end

    // result strobe
    always_ff @(posedge clk) begin
        if (!rstn) begin
            ren_valid <= 1'b0;
        end else begin
            ren_valid <= accept;  // one cycle per accepted dispatch
        end
    end

    // result fields, only meaningful with ren_valid
    always_ff @(posedge clk) begin
        if (accept) begin
            ren_sr1_p <= sr1_p;
            ren_sr2_p <= sr2_p;
            ren_dr_p  <= free_head;
            ren_old_p <= alias_tbl[disp_dr];
            ren_rob   <= tail;
        end
    end

endmodule

// File: rob_entry.sv
/* reorder buffer slot */

`timescale 1ns/1ps

module rob_entry #(
    parameter int ENTRY_ID   = 0,
    parameter int PREG_COUNT = 48,
    parameter int ROB_DEPTH  = 16
) (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              alloc,
    input  logic [$clog2(ROB_DEPTH)-1:0]      alloc_rob,
    input  logic [rename_pkg::AREG_W-1:0]     alloc_areg,
    input  logic [$clog2(PREG_COUNT)-1:0]     alloc_preg,
    input  logic [$clog2(PREG_COUNT)-1:0]     alloc_old,
    input  logic                              cmpl_valid,
    input  logic [$clog2(ROB_DEPTH)-1:0]      cmpl_rob,
    input  logic                              retire,
    input  logic [$clog2(ROB_DEPTH)-1:0]      retire_rob,
    output rename_pkg::entry_state_t          state,
    output logic [rename_pkg::AREG_W-1:0]     areg,
    output logic [$clog2(PREG_COUNT)-1:0]     preg,
    output logic [$clog2(PREG_COUNT)-1:0]     old_preg
);

    localparam int ROB_W = $clog2(ROB_DEPTH);
    localparam logic [ROB_W-1:0] MY_ID = ROB_W'(ENTRY_ID);

    logic hit_alloc;
    logic hit_cmpl;
    logic hit_retire;

    assign hit_alloc  = alloc & (alloc_rob == MY_ID);
    assign hit_cmpl   = cmpl_valid & (cmpl_rob == MY_ID);
    assign hit_retire = retire & (retire_rob == MY_ID);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= rename_pkg::ENTRY_EMPTY;
        end else begin
            case (state)
                rename_pkg::ENTRY_EMPTY: if (hit_alloc)  state <= rename_pkg::ENTRY_BUSY;
                rename_pkg::ENTRY_BUSY:  if (hit_cmpl)   state <= rename_pkg::ENTRY_DONE;
                rename_pkg::ENTRY_DONE:  if (hit_retire) state <= rename_pkg::ENTRY_EMPTY;
                default:                 state <= rename_pkg::ENTRY_EMPTY;
            endcase
        end
    end

    // captured once per allocation, held until the slot is reused
    always_ff @(posedge clk) begin
        if (hit_alloc && state == rename_pkg::ENTRY_EMPTY) begin
            areg     <= alloc_areg;
            preg     <= alloc_preg;
            old_preg <= alloc_old;
        end
    end

endmodule

// File: rob_control.sv
/* rob head and in-order retire */

`timescale 1ns/1ps

module rob_control #(
    parameter int PREG_COUNT = 48,
    parameter int ROB_DEPTH  = 16
) (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              alloc,
    input  rename_pkg::entry_state_t          entry_state [ROB_DEPTH],
    input  logic [rename_pkg::AREG_W-1:0]     entry_areg  [ROB_DEPTH],
    input  logic [$clog2(PREG_COUNT)-1:0]     entry_preg  [ROB_DEPTH],
    input  logic [$clog2(PREG_COUNT)-1:0]     entry_old   [ROB_DEPTH],
    output logic                              rob_full,
    output logic                              retire,
    output logic [$clog2(ROB_DEPTH)-1:0]      retire_rob,
    output logic                              push,
    output logic [$clog2(PREG_COUNT)-1:0]     push_preg,
    output logic                              ret_valid,
    output logic [rename_pkg::AREG_W-1:0]     ret_areg,
    output logic [$clog2(PREG_COUNT)-1:0]     ret_preg,
    output logic [$clog2(ROB_DEPTH)-1:0]      ret_rob
);

    localparam int ROB_W = $clog2(ROB_DEPTH);

    logic [ROB_W-1:0] head;   // oldest instruction in flight
    logic [ROB_W:0]   count;  // one extra bit to hold ROB_DEPTH

    assign rob_full = (count == (ROB_W+1)'(ROB_DEPTH));

    // head done -> retire it this cycle, one per cycle at most
    assign retire     = (entry_state[head] == rename_pkg::ENTRY_DONE);
    assign retire_rob = head;
    assign push       = retire;
    assign push_preg  = entry_old[head];  // displaced mapping goes back to the pool

    always_ff @(posedge clk) begin
        if (!rstn) begin
            head  <= '0;
            count <= '0;
        end else begin
            if (retire) begin
                head <= head + 1'b1;
            end
            case ({alloc, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            ret_valid <= 1'b0;
        end else begin
            ret_valid <= retire;
        end
    end

    // retire report, valid with ret_valid
    always_ff @(posedge clk) begin
        if (retire) begin
            ret_areg <= entry_areg[head];
            ret_preg <= entry_preg[head];
            ret_rob  <= head;
        end
    end

endmodule

// File: rename_top.sv
/* rename and retire top */

`timescale 1ns/1ps

module rename_top #(
    parameter int PREG_COUNT = 48,  // must exceed AREG_COUNT
    parameter int ROB_DEPTH  = 16   // power of two
) (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              disp_valid,
    input  logic [rename_pkg::AREG_W-1:0]     disp_sr1,
    input  logic [rename_pkg::AREG_W-1:0]     disp_sr2,
    input  logic [rename_pkg::AREG_W-1:0]     disp_dr,
    input  logic                              disp_imm,
    input  logic                              cmpl_valid,
    input  logic [$clog2(ROB_DEPTH)-1:0]      cmpl_rob,
    output logic                              stall,
    output logic                              ren_valid,
    output logic [$clog2(PREG_COUNT)-1:0]     ren_sr1_p,
    output logic [$clog2(PREG_COUNT)-1:0]     ren_sr2_p,
    output logic [$clog2(PREG_COUNT)-1:0]     ren_dr_p,
    output logic [$clog2(PREG_COUNT)-1:0]     ren_old_p,
    output logic [$clog2(ROB_DEPTH)-1:0]      ren_rob,
    output logic                              ret_valid,
    output logic [rename_pkg::AREG_W-1:0]     ret_areg,
    output logic [$clog2(PREG_COUNT)-1:0]     ret_preg,
    output logic [$clog2(ROB_DEPTH)-1:0]      ret_rob
);

    localparam int PREG_W = $clog2(PREG_COUNT);
    localparam int ROB_W  = $clog2(ROB_DEPTH);

    // free list <-> map / retire
    logic [PREG_W-1:0] free_head;
    logic              free_empty;
    logic              pop;
    logic              push;
    logic [PREG_W-1:0] push_preg;

    // map -> rob
    logic                          alloc;
    logic [ROB_W-1:0]              alloc_rob;
    logic [rename_pkg::AREG_W-1:0] alloc_areg;
    logic [PREG_W-1:0]             alloc_preg;
    logic [PREG_W-1:0]             alloc_old;
    logic                          rob_full;

    // rob control <-> entries
    logic                          retire;
    logic [ROB_W-1:0]              retire_rob;
    rename_pkg::entry_state_t      entry_state [ROB_DEPTH];
    logic [rename_pkg::AREG_W-1:0] entry_areg  [ROB_DEPTH];
    logic [PREG_W-1:0]             entry_preg  [ROB_DEPTH];
    logic [PREG_W-1:0]             entry_old   [ROB_DEPTH];

    free_list #(
        .PREG_COUNT (PREG_COUNT)
    ) free_list_i (
        .clk        (clk),
        .rstn       (rstn),
        .pop        (pop),
        .push       (push),
        .push_preg  (push_preg),
        .free_head  (free_head),
        .free_empty (free_empty)
    );

    rename_map #(
        .PREG_COUNT (PREG_COUNT),
        .ROB_DEPTH  (ROB_DEPTH)
    ) rename_map_i (
        .clk        (clk),
        .rstn       (rstn),
        .disp_valid (disp_valid),
        .disp_sr1   (disp_sr1),
        .disp_sr2   (disp_sr2),
        .disp_dr    (disp_dr),
        .disp_imm   (disp_imm),
        .free_head  (free_head),
        .free_empty (free_empty),
        .pop        (pop),
        .rob_full   (rob_full),
        .alloc      (alloc),
        .alloc_rob  (alloc_rob),
        .alloc_areg (alloc_areg),
        .alloc_preg (alloc_preg),
        .alloc_old  (alloc_old),
        .stall      (stall),
        .ren_valid  (ren_valid),
        .ren_sr1_p  (ren_sr1_p),
        .ren_sr2_p  (ren_sr2_p),
        .ren_dr_p   (ren_dr_p),
        .ren_old_p  (ren_old_p),
        .ren_rob    (ren_rob)
    );

    rob_control #(
        .PREG_COUNT  (PREG_COUNT),
        .ROB_DEPTH   (ROB_DEPTH)
    ) rob_control_i (
        .clk         (clk),
        .rstn        (rstn),
        .alloc       (alloc),
        .entry_state (entry_state),
        .entry_areg  (entry_areg),
        .entry_preg  (entry_preg),
        .entry_old   (entry_old),
        .rob_full    (rob_full),
        .retire      (retire),
        .retire_rob  (retire_rob),
        .push        (push),
        .push_preg   (push_preg),
        .ret_valid   (ret_valid),
        .ret_areg    (ret_areg),
        .ret_preg    (ret_preg),
        .ret_rob     (ret_rob)
    );

    // one slot per rob index, each decodes its own strobes
    for (genvar g = 0; g < ROB_DEPTH; g++) begin : g_rob
        rob_entry #(
            .ENTRY_ID   (g),
            .PREG_COUNT (PREG_COUNT),
            .ROB_DEPTH  (ROB_DEPTH)
        ) rob_entry_i (
            .clk        (clk),
            .rstn       (rstn),
            .alloc      (alloc),
            .alloc_rob  (alloc_rob),
            .alloc_areg (alloc_areg),
            .alloc_preg (alloc_preg),
            .alloc_old  (alloc_old),
            .cmpl_valid (cmpl_valid),
            .cmpl_rob   (cmpl_rob),
            .retire     (retire),
            .retire_rob (retire_rob),
            .state      (entry_state[g]),
            .areg       (entry_areg[g]),
            .preg       (entry_preg[g]),
            .old_preg   (entry_old[g])
        );
    end

endmodule

// File: tb_rename.sv
/* rename subsystem testbench */

`timescale 1ns/1ps

module tb_rename;

    // 400 random dispatches at roughly two cycles each plus short directed tests
    localparam int MAX_CYCLES = 5000;

    logic       clk = 1'b0;
    logic       rstn;
    logic       disp_valid, disp_imm, cmpl_valid;
    logic [4:0] disp_sr1, disp_sr2, disp_dr;
    logic [3:0] cmpl_rob;
    logic       stall, ren_valid, ret_valid;
    logic [5:0] ren_sr1_p, ren_sr2_p, ren_dr_p, ren_old_p, ret_preg;
    logic [3:0] ren_rob, ret_rob;
    logic [4:0] ret_areg;

    int    map_m [32];          // areg -> preg
    int    free_q [$];          // front is the next pop
    int    st_m [16];           // 0 empty, 1 busy, 2 done
    int    areg_m [16];
    int    preg_m [16];
    int    old_m [16];
    int    head_m, tail_m, cnt_m;
    bit    exp_ren, exp_ret;    // strobes due after the last edge
    int    exp_sr1, exp_sr2, exp_dr, exp_old, exp_rob, exp_areg, exp_preg, exp_rrob;
    int    errors, cycles, test_err, tests_run, tests_failed;
    string test_name;

    rename_top dut_i (.*);

    always #50 clk = ~clk;

    function void model_reset();
        free_q = {};
        for (int i = 0; i < 32; i++) map_m[i] = i;        // identity map
        for (int i = 32; i < 48; i++) free_q.push_back(i);
        for (int i = 0; i < 16; i++) st_m[i] = 0;
        head_m = 0;
        tail_m = 0;
        cnt_m = 0;
        exp_ren = 0;
        exp_ret = 0;
    endfunction

    // one clock edge of the subsystem with all decisions on the state before the edge
    function void model_step(input bit dv, input int s1, input int s2, input int d,
                             input bit imm, input bit cv, input int cr);
        bit acc;
        bit ret;
        bit hit;
        int freed;
        acc = dv && free_q.size() != 0 && cnt_m != 16;
        ret = (st_m[head_m] == 2);
        hit = cv && st_m[cr] == 1;                      // completion of a non-busy slot is dropped
        exp_ren = acc;
        exp_ret = ret;
        if (ret) begin
            exp_areg = areg_m[head_m];
            exp_preg = preg_m[head_m];
            exp_rrob = head_m;
            freed = old_m[head_m];
            st_m[head_m] = 0;
            head_m = (head_m + 1) % 16;
        end
        if (hit) st_m[cr] = 2;
        if (acc) begin
            exp_sr1 = map_m[s1];
            exp_sr2 = imm ? 0 : map_m[s2];
            exp_dr = free_q.pop_front();
            exp_old = map_m[d];
            exp_rob = tail_m;
            map_m[d] = exp_dr;
            st_m[tail_m] = 1;
            areg_m[tail_m] = d;
            preg_m[tail_m] = exp_dr;
            old_m[tail_m] = exp_old;
            tail_m = (tail_m + 1) % 16;
        end
        if (ret) free_q.push_back(freed);               // back of the fifo behind this pop
        cnt_m = cnt_m + int'(acc) - int'(ret);
    endfunction

    function void value_error(input string what, input int got, input int want);
        $display("** Error at %0d ns: %s is %0d, expected %0d", $time, what, got, want);
        errors++;
    endfunction

    function void strobe_error(input string what);
        $display("at %0d ns the %s", $time, what);
        errors++;
    endfunction

    function void check_outputs();
        bit want_stall;
        want_stall = (free_q.size() == 0) || (cnt_m == 16);
        assert (stall == want_stall) else value_error("stall", stall, want_stall);
        assert (ren_valid == exp_ren)
            else strobe_error(exp_ren ? "rename strobe is missing" : "rename strobe was not due");
        assert (ret_valid == exp_ret)
            else strobe_error(exp_ret ? "retire strobe is missing" : "retire strobe was not due");
        if (ren_valid && exp_ren) begin
            assert (ren_sr1_p == exp_sr1) else value_error("ren_sr1_p", ren_sr1_p, exp_sr1);
            assert (ren_sr2_p == exp_sr2) else value_error("ren_sr2_p", ren_sr2_p, exp_sr2);
            assert (ren_dr_p == exp_dr) else value_error("ren_dr_p", ren_dr_p, exp_dr);
            assert (ren_old_p == exp_old) else value_error("ren_old_p", ren_old_p, exp_old);
            assert (ren_rob == exp_rob) else value_error("ren_rob", ren_rob, exp_rob);
        end
        if (ret_valid && exp_ret) begin
            assert (ret_areg == exp_areg) else value_error("ret_areg", ret_areg, exp_areg);
            assert (ret_preg == exp_preg) else value_error("ret_preg", ret_preg, exp_preg);
            assert (ret_rob == exp_rrob) else value_error("ret_rob", ret_rob, exp_rrob);
        end
    endfunction

    // outputs checked against the last edge before the model takes this edge
    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run still going after %0d cycles", MAX_CYCLES);
            $display("SOME TESTS FAILED");
            $finish;
        end else if (!rstn) begin
            model_reset();
        end else begin
            check_outputs();
            model_step(disp_valid, disp_sr1, disp_sr2, disp_dr, disp_imm, cmpl_valid, cmpl_rob);
        end
    end

    task automatic apply(input bit dv, input int s1, input int s2, input int d, input bit imm,
                         input bit cv, input int cr);
        disp_valid = dv;
        disp_sr1   = 5'(s1);
        disp_sr2   = 5'(s2);
        disp_dr    = 5'(d);
        disp_imm   = imm;
        cmpl_valid = cv;
        cmpl_rob   = 4'(cr);
    endtask

    task automatic drive(input bit dv, input int s1, input int s2, input int d, input bit imm,
                         input bit cv, input int cr);
        @(negedge clk);
        apply(dv, s1, s2, d, imm, cv, cr);
    endtask

    // repeats the strobe while stalled
    task automatic dispatch(input int s1, input int s2, input int d, input bit imm);
        do drive(1, s1, s2, d, imm, 0, 0); while (stall);
    endtask

    // completes busy slots until the rob is empty and the last strobes are checked
    task automatic drain();
        int slot;
        do begin
            @(negedge clk);
            slot = -1;
            for (int i = 0; i < 16; i++) if (st_m[i] == 1 && slot < 0) slot = i;
            apply(0, 0, 0, 0, 0, slot >= 0, (slot < 0) ? 0 : slot);
        end while (cnt_m != 0 || exp_ret || exp_ren);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_err  = errors;
    endtask

    task automatic end_test();
        drain();
        tests_run++;
        if (errors == test_err) begin
            $display("test %0d %s: ok", tests_run, test_name);
        end else begin
            $display("test %0d %s: failed, %0d errors", tests_run, test_name, errors - test_err);
            tests_failed++;
        end
    endtask

    initial begin
        int accepted;
        int busy [$];
        bit dv;
        bit cv;
        int base;
        void'($urandom(32'h40e7));
        rstn = 1'b0;
        apply(0, 0, 0, 0, 0, 0, 0);
        repeat (2) @(negedge clk);
        rstn = 1'b1;

        start_test("first rename");
        dispatch(3, 7, 1, 0);
        drive(0, 0, 0, 0, 0, 0, 0);                    // result registered one edge later
        assert (ren_valid) else strobe_error("rename strobe is missing after the first dispatch");
        assert (ren_sr1_p == 3) else value_error("first rename ren_sr1_p", ren_sr1_p, 3);
        assert (ren_sr2_p == 7) else value_error("first rename ren_sr2_p", ren_sr2_p, 7);
        assert (ren_dr_p == 32) else value_error("first rename ren_dr_p", ren_dr_p, 32);
        assert (ren_rob == 0) else value_error("first rename ren_rob", ren_rob, 0);
        end_test();

        start_test("dependent chain");
        for (int i = 0; i < 6; i++) dispatch(5, i, 5, 0);   // r5 = f(r5, ri)
        end_test();

        start_test("immediate");
        dispatch(9, 12, 14, 1);
        drive(0, 0, 0, 0, 0, 0, 0);
        assert (ren_valid) else strobe_error("rename strobe is missing after the imm dispatch");
        assert (ren_sr2_p == 0) else value_error("imm ren_sr2_p", ren_sr2_p, 0);
        end_test();

        start_test("stall and wrap");
        for (int i = 0; i < 16; i++) dispatch(i, (i + 5) % 32, (i + 9) % 32, 0);
        drive(1, 1, 2, 3, 0, 0, 0);                    // dropped since rob and free list are exhausted
        assert (stall) else value_error("stall when full", stall, 1);
        drive(0, 0, 0, 0, 0, 1, head_m);
        dispatch(4, 4, 4, 0);                          // lands on the slot just retired
        end_test();

        start_test("out of order completion");
        base = tail_m;
        for (int i = 0; i < 4; i++) dispatch(i, i + 1, i + 20, 0);
        for (int i = 3; i >= 0; i--) drive(0, 0, 0, 0, 0, 1, (base + i) % 16);
        for (int i = 0; i < 16; i++) dispatch(i, i + 1, (i * 3) % 32, 0);
        end_test();

        start_test("random mix");
        accepted = 0;
        while (accepted < 400) begin
            @(negedge clk);
            busy.delete();
            for (int i = 0; i < 16; i++) if (st_m[i] == 1) busy.push_back(i);
            dv = ($urandom % 4) != 0;
            cv = (busy.size() != 0) && ($urandom % 2 == 1);
            apply(dv, $urandom % 32, $urandom % 32, $urandom % 32, ($urandom % 4) == 0,
                  cv, cv ? busy[$urandom % busy.size()] : 0);
            if (dv && !stall) accepted++;
        end
        end_test();

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: files.f
rename_pkg.sv
free_list.sv
rename_map.sv
rob_entry.sv
rob_control.sv
rename_top.sv
tb_rename.sv

// File: Makefile
TB = tb_rename

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f files.f --top-module rename_top

sim:
	verilator --binary --timing -j 0 -f files.f --top-module $(TB)
	@out="$$(obj_dir/V$(TB))"; echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
